// File: Makefile
# Verilator build and run of the MLP classifier testbench

VERILATOR ?= verilator
TOP ?= mlpClassifierTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing -j $(JOBS)
PASS_MSG ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR)"
	@echo "  TOP=$(TOP)"
	@echo "  FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR)"
	@echo "  JOBS=$(JOBS)"
	@echo "  VFLAGS=$(VFLAGS)"

test:
	$(VERILATOR) $(VFLAGS) -Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: bench/mlpModel.svh
`ifndef MLP_MODEL_SVH
`define MLP_MODEL_SVH

// clip a wide sum into the Q8.8 range
function automatic nnPkg::activation clipToActivation(input longint x);
	nnPkg::activation y;
	if (x > 32767)
		y = 16'sh7FFF;
	else if (x < -32768)
		y = 16'sh8000;
	else
		y = x[15:0];
	return y;
endfunction

// only the first count entries of x and w take part in the sum
function automatic nnPkg::activation neuronOutput(
	input int count,
	input nnPkg::activation x [nnPkg::NumFeatures],
	input nnPkg::weight w [nnPkg::NumFeatures],
	input nnPkg::weight bias,
	input bit rectify
);
	longint sum;
	longint product;
	nnPkg::activation y;
	sum = longint'(bias);
	for (int i = 0; i < count; i++)
	begin
		product = longint'(x[i]) * longint'(w[i]);
		sum = sum + (product >>> nnPkg::FracBits);
	end
	y = clipToActivation(sum);
	if (rectify && y < 0)
		y = '0;
	return y;
endfunction

function automatic nnPkg::hiddenVector hiddenModel(input nnPkg::featureVector f);
	nnPkg::activation x [nnPkg::NumFeatures];
	nnPkg::weight w [nnPkg::NumFeatures];
	nnPkg::hiddenVector h;
	for (int n = 0; n < nnPkg::NumHidden; n++)
	begin
		for (int i = 0; i < nnPkg::NumFeatures; i++)
		begin
			x[i] = f[i];
			w[i] = nnPkg::HiddenWeights[n * nnPkg::NumFeatures + i];
		end
		h[n] = neuronOutput(nnPkg::NumFeatures, x, w, nnPkg::HiddenBiases[n], 1'b1);
	end
	return h;
endfunction

function automatic nnPkg::scoreVector scoreModel(input nnPkg::hiddenVector h);
	nnPkg::activation x [nnPkg::NumFeatures];
	nnPkg::weight w [nnPkg::NumFeatures];
	nnPkg::scoreVector s;
	for (int n = 0; n < nnPkg::NumClasses; n++)
	begin
		for (int i = 0; i < nnPkg::NumFeatures; i++)
		begin
			x[i] = '0;
			w[i] = '0;
		end
		for (int i = 0; i < nnPkg::NumHidden; i++)
		begin
			x[i] = h[i];
			w[i] = nnPkg::OutputWeights[n * nnPkg::NumHidden + i];
		end
		s[n] = neuronOutput(nnPkg::NumHidden, x, w, nnPkg::OutputBiases[n], 1'b0);
	end
	return s;
endfunction

// a later class has to beat the best so far outright, so ties keep the lower index
function automatic nnPkg::classResult classModel(input nnPkg::scoreVector s);
	nnPkg::classResult r;
	nnPkg::activation best;
	nnPkg::activation candidate;
	best = s[0];
	r.index = '0;
	for (int i = 1; i < nnPkg::NumClasses; i++)
	begin
		candidate = s[i];
		if (candidate > best)
		begin
			best = candidate;
			r.index = nnPkg::classIndex'(i);
		end
	end
	r.score = best;
	return r;
endfunction

function automatic nnPkg::classResult resultModel(input nnPkg::featureVector f);
	return classModel(scoreModel(hiddenModel(f)));
endfunction

`endif

// File: bench/mlpClassifierTb.sv
module mlpClassifierTb;

	timeunit 1ns;
	timeprecision 100ps;

	import nnPkg::*;

	`include "mlpModel.svh"

	localparam int HistoryDepth = 2048;
	// the tests take about 320 cycles
	localparam int TimeoutCycles = 2000;

	logic clk;
	logic reset;
	featureVector features;
	hiddenVector hiddenActs;
	classResult result;

	int cycle = 0;
	int errors = 0;
	int checks = 0;
	logic [31:0] lcgState;

	// what was driven in the period after each edge
	featureVector featureHistory [HistoryDepth];
	bit resetHistory [HistoryDepth];

	mlpClassifier #(
		.HiddenWeights(HiddenWeights),
		.HiddenBiases(HiddenBiases),
		.OutputWeights(OutputWeights),
		.OutputBiases(OutputBiases)
	) DUT (
		.clk(clk),
		.reset(reset),
		.features(features),
		.hiddenActs(hiddenActs),
		.result(result)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= TimeoutCycles)
		begin
			$display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] state);
		return (state * 32'd1103515245 + 32'd12345) & 32'h7FFFFFFF;
	endfunction

	function automatic featureVector randomVector();
		featureVector f;
		activation sample;
		for (int i = 0; i < NumFeatures; i++)
		begin
			lcgState = nextRandom(lcgState);
			sample = lcgState[30:15];
			// the shift keeps every value within sixteen units
			f[i] = sample >>> 3;
		end
		return f;
	endfunction

	// counts the edges back to the latest reset edge and gives 7 when none is in reach
	function automatic int edgesSinceReset(input int edgeCount);
		int age;
		age = 7;
		for (int d = 6; d >= 0; d--)
		begin
			if (edgeCount - 1 - d < 0 || resetHistory[edgeCount - 1 - d])
				age = d;
		end
		return age;
	endfunction

	task automatic compareValue(input longint actual, input longint expected, input string what);
		checks++;
		if (actual != expected)
		begin
			errors++;
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, actual, expected);
		end
	endtask

	task automatic checkOutputs();
		int age;
		hiddenVector expHidden;
		classResult expResult;
		activation got;
		activation want;
		age = edgesSinceReset(cycle);
		// a refilling pipeline shows zeros, then the class of an all-zero vector
		if (age <= 2)
		begin
			expHidden = '0;
			expResult = '0;
		end
		else
		begin
			expHidden = hiddenModel(featureHistory[cycle - 3]);
			if (age <= 6)
				expResult = resultModel('0);
			else
				expResult = resultModel(featureHistory[cycle - 7]);
		end
		for (int n = 0; n < NumHidden; n++)
		begin
			got = hiddenActs[n];
			want = expHidden[n];
			compareValue(longint'(got), longint'(want), $sformatf("hiddenActs[%0d]", n));
		end
		compareValue(longint'(result.index), longint'(expResult.index), "result.index");
		got = result.score;
		want = expResult.score;
		compareValue(longint'(got), longint'(want), "result.score");
	endtask

	// outputs are checked before the next inputs go in
	task automatic stepCycle(input featureVector f, input logic r);
		@(posedge clk);
		#10;
		checkOutputs();
		features = f;
		reset = r;
		featureHistory[cycle] = f;
		resetHistory[cycle] = r;
	endtask

	task automatic flushPipeline();
		for (int i = 0; i < 8; i++)
			stepCycle('0, 1'b0);
	endtask

	task automatic resetTest();
		for (int i = 0; i < 3; i++)
			stepCycle(randomVector(), 1'b1);
		stepCycle('0, 1'b0);
		compareValue(longint'(result), 0, "result right after reset");
		flushPipeline();
	endtask

	task automatic zeroTieTest();
		weight bias;
		activation got;
		flushPipeline();
		// classes 1 and 2 tie on their bias
		bias = OutputBiases[1];
		got = result.score;
		compareValue(longint'(hiddenActs), 0, "hiddenActs for zero features");
		compareValue(longint'(result.index), 1, "tie class index");
		compareValue(longint'(got), longint'(bias), "tie class score");
	endtask

	task automatic rectifyTest();
		featureVector f;
		for (int i = 0; i < NumFeatures; i++)
		begin
			f = '0;
			f[i] = 16'sh0180;
			stepCycle(f, 1'b0);
			f[i] = -16'sh0180;
			stepCycle(f, 1'b0);
		end
		flushPipeline();
	endtask

	task automatic saturationTest();
		featureVector f;
		weight w;
		stepCycle({NumFeatures{16'sh7FFF}}, 1'b0);
		stepCycle({NumFeatures{16'sh8000}}, 1'b0);
		// signs follow node 0 so every product adds to its sum
		for (int i = 0; i < NumFeatures; i++)
		begin
			w = HiddenWeights[i];
			f[i] = (w < 0) ? 16'sh8000 : 16'sh7FFF;
		end
		stepCycle(f, 1'b0);
		flushPipeline();
	endtask

	task automatic streamTest();
		for (int i = 0; i < 200; i++)
			stepCycle(randomVector(), 1'b0);
		flushPipeline();
	endtask

	task automatic resetMidStreamTest();
		for (int i = 0; i < 40; i++)
			stepCycle(randomVector(), (i == 15 || i == 16));
		flushPipeline();
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		features = '0;
		lcgState = 32'd7;
		featureHistory[0] = '0;
		resetHistory[0] = 1'b1;
		resetTest();
		zeroTieTest();
		rectifyTest();
		saturationTest();
		streamTest();
		resetMidStreamTest();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: logic/classSelect.sv
module classSelect #(
	parameter int NumClasses = nnPkg::NumClasses
) (
	input logic clk,
	input logic reset,
	input nnPkg::scoreVector scores,
	output nnPkg::classResult result
);

	import nnPkg::*;

	localparam int Levels = $clog2(NumClasses);
	localparam int Width = 1 << Levels;

	classResult stage [Levels+1][Width];
	logic stageValid [Levels+1][Width];

	// pairwise tree, the left entry of a pair always has the lower index
	always_comb
	begin
		classResult left;
		classResult right;
		stage = '{default: '0};
		stageValid = '{default: 1'b0};
		for (int i = 0; i < NumClasses; i++)
		begin
			stage[0][i].index = classIndex'(i);
			stage[0][i].score = scores[i];
			stageValid[0][i] = 1'b1;
		end
		for (int l = 0; l < Levels; l++)
		begin
			for (int i = 0; i < (Width >> (l + 1)); i++)
			begin
				left = stage[l][2*i];
				right = stage[l][2*i+1];
				// a strict compare lets the lower index win a tie
				if (stageValid[l][2*i+1] && right.score > left.score)
				begin
					stage[l+1][i] = right;
				end
				else
				begin
					stage[l+1][i] = left;
				end
				stageValid[l+1][i] = stageValid[l][2*i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			result <= '0;
		else
			result <= stage[Levels][0];
	end

endmodule

// File: logic/denseLayer.sv
module denseLayer #(
	parameter int NumInputs = nnPkg::NumFeatures,
	parameter int NumNodes = nnPkg::NumHidden,
	parameter nnPkg::weight [NumNodes*NumInputs-1:0] Weights = '0,
	parameter nnPkg::weight [NumNodes-1:0] Biases = '0,
	parameter bit Rectify = 1'b1
) (
	input logic clk,
	input logic reset,
	input nnPkg::activation [NumInputs-1:0] inputs,
	output nnPkg::activation [NumNodes-1:0] outputs
);

	import nnPkg::*;

	// all nodes see the same inputs, so the layer latency is that of one neuron
	for (genvar n = 0; n < NumNodes; n++)
	begin : gNode
		// row n of the table belongs to node n
		localparam weight [NumInputs-1:0] NodeWeights = Weights[n*NumInputs +: NumInputs];
		localparam weight NodeBias = Biases[n];

		neuron #(
			.NumInputs(NumInputs),
			.Weights(NodeWeights),
			.Bias(NodeBias),
			.Rectify(Rectify)
		) node (
			.clk(clk),
			.reset(reset),
			.inputs(inputs),
			.value(outputs[n])
		);
	end

endmodule

// File: logic/mlpClassifier.sv
module mlpClassifier #(
	parameter nnPkg::hiddenWeightTable HiddenWeights = nnPkg::HiddenWeights,
	parameter nnPkg::hiddenBiasTable HiddenBiases = nnPkg::HiddenBiases,
	parameter nnPkg::outputWeightTable OutputWeights = nnPkg::OutputWeights,
	parameter nnPkg::outputBiasTable OutputBiases = nnPkg::OutputBiases
) (
	input logic clk,
	input logic reset,
	input nnPkg::featureVector features,
	output nnPkg::hiddenVector hiddenActs,
	output nnPkg::classResult result
);

	import nnPkg::*;

	scoreVector scores;

	// hidden layer, features at edge k reach hiddenActs after edge k+3
	denseLayer #(
		.NumInputs(NumFeatures),
		.NumNodes(NumHidden),
		.Weights(HiddenWeights),
		.Biases(HiddenBiases),
		.Rectify(1'b1)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inputs(features),
		.outputs(hiddenActs)
	);

	// output layer is linear so the scores keep their sign
	denseLayer #(
		.NumInputs(NumHidden),
		.NumNodes(NumClasses),
		.Weights(OutputWeights),
		.Biases(OutputBiases),
		.Rectify(1'b0)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inputs(hiddenActs),
		.outputs(scores)
	);

	// one more register puts the result seven edges behind the features
	classSelect #(
		.NumClasses(NumClasses)
	) selector (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.result(result)
	);

endmodule

// File: logic/neuron.sv
module neuron #(
	parameter int NumInputs = nnPkg::NumFeatures,
	parameter nnPkg::weight [NumInputs-1:0] Weights = '0,
	parameter nnPkg::weight Bias = '0,
	parameter bit Rectify = 1'b1
) (
	input logic clk,
	input logic reset,
	input nnPkg::activation [NumInputs-1:0] inputs,
	output nnPkg::activation value
);

	import nnPkg::*;

	localparam int ActBits = $bits(activation);
	localparam accumulator ActMax = accumulator'((2 ** (ActBits - 1)) - 1);
	localparam accumulator ActMin = accumulator'(-(2 ** (ActBits - 1)));

	activation [NumInputs-1:0] inputRegs;
	accumulator products [NumInputs];
	accumulator total;
	activation sumReg;

	// clip a wide sum into the activation range
	function automatic activation saturate(accumulator x);
		activation clipped;
		if (x > ActMax)
			clipped = activation'(ActMax);
		else if (x < ActMin)
			clipped = activation'(ActMin);
		else
			clipped = activation'(x);
		return clipped;
	endfunction

	// every product is formed in parallel and rescaled to Q8.8
	always_comb
	begin
		for (int i = 0; i < NumInputs; i++)
		begin
			products[i] = (accumulator'(inputRegs[i]) * accumulator'(Weights[i])) >>> FracBits;
		end
	end

	always_comb
	begin
		total = accumulator'(Bias);
		for (int i = 0; i < NumInputs; i++)
		begin
			total = total + products[i];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			inputRegs <= '0;
		else
			inputRegs <= inputs;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			sumReg <= '0;
		else
			sumReg <= saturate(total);
	end

	// the output layer leaves Rectify off and passes negative scores through
	always_ff @(posedge clk)
	begin
		if (reset)
			value <= '0;
		else if (Rectify && sumReg < 0)
			value <= '0;
		else
			value <= sumReg;
	end

endmodule

// File: logic/nnPkg.sv
package nnPkg;

	localparam int FracBits = 8;
	localparam int NumFeatures = 10;
	localparam int NumHidden = 4;
	localparam int NumClasses = 3;

	// Q8.8 values carried between the layers
	typedef logic signed [15:0] activation;
	typedef logic signed [15:0] weight;
	typedef logic signed [31:0] accumulator;
	typedef logic [1:0] classIndex;

	typedef activation [NumFeatures-1:0] featureVector;
	typedef activation [NumHidden-1:0] hiddenVector;
	typedef activation [NumClasses-1:0] scoreVector;

	typedef struct packed {
		classIndex index;
		activation score;
	} classResult;

	// tables are indexed as node * inputs + input
	typedef weight [NumHidden*NumFeatures-1:0] hiddenWeightTable;
	typedef weight [NumHidden-1:0] hiddenBiasTable;
	typedef weight [NumClasses*NumHidden-1:0] outputWeightTable;
	typedef weight [NumClasses-1:0] outputBiasTable;

	// entries are listed from the highest index down
	localparam hiddenWeightTable HiddenWeights = {
		// node 3
		16'sh0180, 16'sh00E0, 16'shFF00, 16'sh0120, 16'sh0100,
		16'sh0040, 16'shFF80, 16'sh01C0, 16'sh0080, 16'shFE40,
		// node 2
		16'sh00A0, 16'shFEC0, 16'sh0180, 16'sh0040, 16'shFFA0,
		16'sh0200, 16'sh0080, 16'shFF00, 16'sh0100, 16'sh0100,
		// node 1
		16'sh0040, 16'sh0120, 16'sh0060, 16'shFF40, 16'sh0180,
		16'sh00C0, 16'shFE00, 16'sh0100, 16'sh0140, 16'shFF80,
		// node 0
		16'shFF00, 16'sh0080, 16'shFFC0, 16'sh0200, 16'sh0040,
		16'shFE80, 16'sh0100, 16'sh00C0, 16'shFF40, 16'sh0180
	};

	// every hidden bias is negative so a zero input rectifies to zero
	localparam hiddenBiasTable HiddenBiases = {
		16'shFFA0, 16'shFFE0, 16'shFF80, 16'shFFC0
	};

	localparam outputWeightTable OutputWeights = {
		// class 2
		16'shFE80, 16'sh0160, 16'sh0060, 16'sh00A0,
		// class 1
		16'sh0100, 16'shFF40, 16'sh0180, 16'shFFC0,
		// class 0
		16'sh00C0, 16'sh0080, 16'shFF80, 16'sh0140
	};

	// classes 1 and 2 share a bias above that of class 0
	localparam outputBiasTable OutputBiases = {
		16'sh0040, 16'sh0040, 16'sh0010
	};

endpackage

// File: verilog.f
+incdir+bench
logic/nnPkg.sv
logic/neuron.sv
logic/denseLayer.sv
logic/classSelect.sv
logic/mlpClassifier.sv
bench/mlpClassifierTb.sv
